//--- include/filter_macros.svh
`ifndef FILTER_MACROS_SVH
`define FILTER_MACROS_SVH

`define FILTER_DATA_W  32
`define FILTER_L2_AW   15
`define FILTER_LEN_W   16
`define FILTER_CFG_AW  5
`define FILTER_SHIFT_W 5

`define FILTER_REG_TXA_ADDR 0
`define FILTER_REG_TXB_ADDR 1
`define FILTER_REG_LEN      2
`define FILTER_REG_RX_ADDR  3
`define FILTER_REG_MODE     4
`define FILTER_REG_AU_CFG   5
`define FILTER_REG_AU_CONST 6
`define FILTER_REG_CTRL     7

`define FILTER_AU_OP_MSB     1
`define FILTER_AU_OP_LSB     0
`define FILTER_AU_SIGNED_BIT 2
`define FILTER_AU_SHIFT_MSB  12
`define FILTER_AU_SHIFT_LSB  8

`endif

//--- rtl/filter_au.sv
module filter_au
(
  input  logic               clk_i,
  input  logic               resetn_i,
  input  filter_pkg::au_op_e op_i,
  input  logic               signed_i,
  input  filter_pkg::shift_t shift_i,
  filter_stream_if.dst       opa,
  filter_stream_if.dst       opb,
  filter_stream_if.src       res
);
  import filter_pkg::*;

  data_t s_raw;
  data_t s_result;
  logic  s_take;
  logic  r_valid;
  logic  r_last;
  data_t r_data;

  // Both operands move together while the output slot is free or draining
  assign s_take    = opa.valid & opb.valid & (~r_valid | res.ready);
  assign opa.ready = s_take;
  assign opb.ready = s_take;

  assign res.valid = r_valid;
  assign res.data  = r_data;
  assign res.last  = r_last;

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_comb
  begin
    case (op_i)
      AU_ADD:  s_raw = opa.data + opb.data;
      AU_SUB:  s_raw = opa.data - opb.data;
      AU_MUL:  s_raw = opa.data * opb.data;    // Keeps the low word
      default: s_raw = opa.data & opb.data;
    endcase

    if (signed_i)
      s_result = data_t'($signed(s_raw) >>> shift_i);
    else
      s_result = s_raw >> shift_i;
  end

  always_ff @(posedge clk_i or negedge resetn_i)
  begin
    if (!resetn_i)
    begin
      r_valid <= 1'b0;
      r_last  <= 1'b0;
    end
    else
    begin
      if (s_take)
      begin
        r_valid <= 1'b1;
        r_last  <= opa.last;
      end
      else if (res.ready)
        r_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (s_take)
      r_data <= s_result;
  end

endmodule

//--- rtl/filter_cfg_regs.sv
`include "filter_macros.svh"

module filter_cfg_regs
(
  input  logic                      clk_i,
  input  logic                      resetn_i,
  input  filter_pkg::cfg_addr_t     cfg_addr_i,
  input  filter_pkg::data_t         cfg_data_i,
  input  logic                      cfg_valid_i,
  input  logic                      cfg_rwn_i,
  output filter_pkg::data_t         cfg_data_o,
  output logic                      cfg_ready_o,
  output filter_pkg::l2_addr_t      txa_addr_o,
  output filter_pkg::l2_addr_t      txb_addr_o,
  output filter_pkg::l2_addr_t      rx_addr_o,
  output filter_pkg::len_t          len_o,
  output filter_pkg::filter_mode_e  mode_o,
  output filter_pkg::au_op_e        au_op_o,
  output logic                      au_signed_o,
  output filter_pkg::shift_t        au_shift_o,
  output filter_pkg::data_t         au_const_o,
  output logic                      start_o,
  input  logic                      done_a_i,
  input  logic                      done_b_i,
  input  logic                      done_out_i,
  output logic                      eot_event_o
);
  import filter_pkg::*;

  logic       s_wr;
  logic       r_start;
  logic       r_busy;
  logic [2:0] r_status;   // Done flags {out, B, A}
  logic [2:0] s_status;
  logic       s_done;
  logic       r_done;

  assign cfg_ready_o = cfg_valid_i;                 // Always ready
  assign s_wr        = cfg_valid_i & ~cfg_rwn_i;
  assign start_o     = r_start;

  //////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge resetn_i)
  begin
    if (!resetn_i)
    begin
      txa_addr_o  <= '0;
      txb_addr_o  <= '0;
      rx_addr_o   <= '0;
      len_o       <= '0;
      mode_o      <= MODE_AB;
      au_op_o     <= AU_ADD;
      au_signed_o <= 1'b0;
      au_shift_o  <= '0;
      au_const_o  <= '0;
      r_start     <= 1'b0;
    end
    else
    begin
      r_start <= s_wr && (cfg_addr_i == `FILTER_REG_CTRL) && cfg_data_i[0];
      if (s_wr)
      begin
        case (cfg_addr_i)
          `FILTER_REG_TXA_ADDR: txa_addr_o <= cfg_data_i[`FILTER_L2_AW-1:0];
          `FILTER_REG_TXB_ADDR: txb_addr_o <= cfg_data_i[`FILTER_L2_AW-1:0];
          `FILTER_REG_LEN:      len_o      <= cfg_data_i[`FILTER_LEN_W-1:0];
          `FILTER_REG_RX_ADDR:  rx_addr_o  <= cfg_data_i[`FILTER_L2_AW-1:0];
          `FILTER_REG_MODE:     mode_o     <= filter_mode_e'(cfg_data_i[0]);
          `FILTER_REG_AU_CFG:
          begin
            au_op_o     <= au_op_e'(cfg_data_i[`FILTER_AU_OP_MSB:`FILTER_AU_OP_LSB]);
            au_signed_o <= cfg_data_i[`FILTER_AU_SIGNED_BIT];
            au_shift_o  <= cfg_data_i[`FILTER_AU_SHIFT_MSB:`FILTER_AU_SHIFT_LSB];
          end
          `FILTER_REG_AU_CONST: au_const_o <= cfg_data_i;
          default: ;
        endcase
      end
    end
  end

  always_comb
  begin
    cfg_data_o = '0;
    case (cfg_addr_i)
      `FILTER_REG_TXA_ADDR: cfg_data_o = data_t'(txa_addr_o);
      `FILTER_REG_TXB_ADDR: cfg_data_o = data_t'(txb_addr_o);
      `FILTER_REG_LEN:      cfg_data_o = data_t'(len_o);
      `FILTER_REG_RX_ADDR:  cfg_data_o = data_t'(rx_addr_o);
      `FILTER_REG_MODE:     cfg_data_o = data_t'(mode_o);
      `FILTER_REG_AU_CFG:
      begin
        cfg_data_o[`FILTER_AU_OP_MSB:`FILTER_AU_OP_LSB]       = au_op_o;
        cfg_data_o[`FILTER_AU_SIGNED_BIT]                     = au_signed_o;
        cfg_data_o[`FILTER_AU_SHIFT_MSB:`FILTER_AU_SHIFT_LSB] = au_shift_o;
      end
      `FILTER_REG_AU_CONST: cfg_data_o = au_const_o;
      `FILTER_REG_CTRL:     cfg_data_o = data_t'({s_done, r_busy});
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // Completion status
  //////////////////////////////////////////////////

  assign s_status    = r_status | {1'b0, mode_o == MODE_A_CONST, 1'b0};  // B unused
  assign s_done      = &s_status;
  assign eot_event_o = s_done & ~r_done;    // Rising edge of all-done

  always_ff @(posedge clk_i or negedge resetn_i)
  begin
    if (!resetn_i)
    begin
      r_status <= '0;
      r_done   <= 1'b0;
      r_busy   <= 1'b0;
    end
    else
    begin
      r_done <= s_done;
      if (r_start)
      begin
        r_status <= '0;
        r_busy   <= 1'b1;
      end
      else
      begin
        r_status <= r_status | {done_out_i, done_b_i, done_a_i};
        if (eot_event_o)
          r_busy <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/filter_fetch_ch.sv
module filter_fetch_ch
(
  input  logic                 clk_i,
  input  logic                 resetn_i,
  input  logic                 start_i,
  input  filter_pkg::l2_addr_t base_addr_i,
  input  filter_pkg::len_t     len_i,
  filter_l2_rd_if.master       rd,
  filter_stream_if.src         out,
  output logic                 done_o
);
  import filter_pkg::*;

  fetch_state_e r_state;
  l2_addr_t     r_addr;
  len_t         r_left;   // Words still to hand out
  data_t        r_data;   // One-word buffer
  logic         s_take;

  assign rd.req    = (r_state == REQ);
  assign rd.addr   = r_addr;
  assign out.valid = (r_state == HOLD);
  assign out.data  = r_data;
  assign out.last  = (r_left == len_t'(1));
  assign s_take    = out.valid & out.ready;
  assign done_o    = s_take & out.last;

  always_ff @(posedge clk_i or negedge resetn_i)
  begin
    if (!resetn_i)
    begin
      r_state <= IDLE;
      r_addr  <= '0;
      r_left  <= '0;
    end
    else
    begin
      case (r_state)
        IDLE:
        begin
          if (start_i)
          begin
            r_addr  <= base_addr_i;
            r_left  <= len_i;
            r_state <= REQ;
          end
        end
        REQ:
        begin
          if (rd.gnt)
            r_state <= WAIT_DATA;
        end
        WAIT_DATA:
        begin
          if (rd.rvalid)
            r_state <= HOLD;
        end
        HOLD:
        begin
          if (s_take)
          begin
            r_left  <= r_left - len_t'(1);
            r_addr  <= r_addr + l2_addr_t'(4);    // Next word
            r_state <= out.last ? IDLE : REQ;
          end
        end
        default: r_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if ((r_state == WAIT_DATA) && rd.rvalid)
      r_data <= rd.rdata;
  end

endmodule

//--- rtl/filter_ifs.sv
// Word stream with valid/ready and a last flag on the final word
interface filter_stream_if;
  import filter_pkg::*;

  data_t data;
  logic  valid;
  logic  ready;
  logic  last;

  modport src
  (
    output data,
    output valid,
    output last,
    input  ready
  );

  modport dst
  (
    input  data,
    input  valid,
    input  last,
    output ready
  );
endinterface

// One L2 read access with req/gnt and a single rvalid carrying rdata
interface filter_l2_rd_if;
  import filter_pkg::*;

  logic     req;
  l2_addr_t addr;
  logic     gnt;
  logic     rvalid;
  data_t    rdata;

  modport master
  (
    output req,
    output addr,
    input  gnt,
    input  rvalid,
    input  rdata
  );

  modport slave
  (
    input  req,
    input  addr,
    output gnt,
    output rvalid,
    output rdata
  );
endinterface

//--- rtl/filter_l2_arbiter.sv
module filter_l2_arbiter
(
  input  logic                 clk_i,
  input  logic                 resetn_i,
  filter_l2_rd_if.slave        ch_a,
  filter_l2_rd_if.slave        ch_b,
  output logic                 l2_rd_req_o,
  output filter_pkg::l2_addr_t l2_rd_addr_o,
  input  logic                 l2_rd_gnt_i,
  input  logic                 l2_rd_rvalid_i,
  input  filter_pkg::data_t    l2_rd_rdata_i
);
  import filter_pkg::*;

  logic r_busy;     // Read outstanding
  logic r_owner;    // 1 when B owns it
  logic r_prio_b;   // B wins a tie
  logic s_sel_b;
  logic s_grant;

  assign s_sel_b      = ch_b.req & (~ch_a.req | r_prio_b);
  assign l2_rd_req_o  = ~r_busy & (ch_a.req | ch_b.req);
  assign l2_rd_addr_o = s_sel_b ? ch_b.addr : ch_a.addr;
  assign s_grant      = l2_rd_req_o & l2_rd_gnt_i;

  assign ch_a.gnt    = s_grant & ~s_sel_b;
  assign ch_b.gnt    = s_grant & s_sel_b;
  assign ch_a.rvalid = l2_rd_rvalid_i & r_busy & ~r_owner;
  assign ch_b.rvalid = l2_rd_rvalid_i & r_busy & r_owner;
  assign ch_a.rdata  = r_owner ? '0 : l2_rd_rdata_i;
  assign ch_b.rdata  = r_owner ? l2_rd_rdata_i : '0;

  always_ff @(posedge clk_i or negedge resetn_i)
  begin
    if (!resetn_i)
    begin
      r_busy   <= 1'b0;
      r_owner  <= 1'b0;
      r_prio_b <= 1'b0;
    end
    else
    begin
      if (s_grant)
      begin
        r_busy   <= 1'b1;
        r_owner  <= s_sel_b;
        r_prio_b <= ~s_sel_b;     // Other channel goes first next time
      end
      else if (l2_rd_rvalid_i)
        r_busy <= 1'b0;
    end
  end

endmodule

//--- rtl/filter_pkg.sv
`include "filter_macros.svh"

package filter_pkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  typedef logic [`FILTER_DATA_W-1:0]  data_t;      // One 32-bit word
  typedef logic [`FILTER_L2_AW-1:0]   l2_addr_t;   // L2 byte address
  typedef logic [`FILTER_LEN_W-1:0]   len_t;       // Word count
  typedef logic [`FILTER_CFG_AW-1:0]  cfg_addr_t;  // Register index
  typedef logic [`FILTER_SHIFT_W-1:0] shift_t;     // Result shift

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  typedef enum logic
  {
    MODE_AB      = 1'b0,  // Operand B from channel B
    MODE_A_CONST = 1'b1   // Operand B from AU_CONST
  } filter_mode_e;

  typedef enum logic [1:0]
  {
    AU_ADD = 2'd0,
    AU_SUB = 2'd1,
    AU_MUL = 2'd2,        // Low half of the product
    AU_AND = 2'd3
  } au_op_e;

  typedef enum logic [1:0]
  {
    IDLE      = 2'd0,
    REQ       = 2'd1,
    WAIT_DATA = 2'd2,
    HOLD      = 2'd3
  } fetch_state_e;

endpackage

//--- rtl/filter_store_ch.sv
module filter_store_ch
(
  input  logic                 clk_i,
  input  logic                 resetn_i,
  input  logic                 start_i,
  input  filter_pkg::l2_addr_t base_addr_i,
  input  filter_pkg::len_t     len_i,
  filter_stream_if.dst         in,
  output logic                 rx_valid_o,
  output filter_pkg::l2_addr_t rx_addr_o,
  output filter_pkg::data_t    rx_data_o,
  input  logic                 rx_ready_i,
  output logic                 done_o
);
  import filter_pkg::*;

  len_t r_in_idx;     // Index of the next word accepted
  len_t r_stored;     // Words written so far
  logic s_take;
  logic s_write;

  assign in.ready = ~rx_valid_o | rx_ready_i;
  assign s_take   = in.valid & in.ready;
  assign s_write  = rx_valid_o & rx_ready_i;
  assign done_o   = s_write & (r_stored == len_i - len_t'(1));

  always_ff @(posedge clk_i or negedge resetn_i)
  begin
    if (!resetn_i)
    begin
      rx_valid_o <= 1'b0;
      r_in_idx   <= '0;
      r_stored   <= '0;
    end
    else
    begin
      if (s_take)
        rx_valid_o <= 1'b1;
      else if (rx_ready_i)
        rx_valid_o <= 1'b0;

      if (start_i)
      begin
        r_in_idx <= '0;
        r_stored <= '0;
      end
      else
      begin
        if (s_take)
          r_in_idx <= r_in_idx + len_t'(1);
        if (s_write)
          r_stored <= r_stored + len_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (s_take)
    begin
      rx_data_o <= in.data;
      rx_addr_o <= base_addr_i + l2_addr_t'({r_in_idx, 2'b00});  // base + 4*index
    end
  end

endmodule

//--- rtl/udma_filter.sv
module udma_filter
(
  input  logic                  clk_i,
  input  logic                  resetn_i,
  input  filter_pkg::cfg_addr_t cfg_addr_i,
  input  filter_pkg::data_t     cfg_data_i,
  input  logic                  cfg_valid_i,
  input  logic                  cfg_rwn_i,
  output filter_pkg::data_t     cfg_data_o,
  output logic                  cfg_ready_o,
  output logic                  l2_rd_req_o,
  output filter_pkg::l2_addr_t  l2_rd_addr_o,
  input  logic                  l2_rd_gnt_i,
  input  logic                  l2_rd_rvalid_i,
  input  filter_pkg::data_t     l2_rd_rdata_i,
  output logic                  rx_valid_o,
  output filter_pkg::l2_addr_t  rx_addr_o,
  output filter_pkg::data_t     rx_data_o,
  input  logic                  rx_ready_i,
  output logic                  eot_event_o
);
  import filter_pkg::*;

  l2_addr_t     s_txa_addr;
  l2_addr_t     s_txb_addr;
  l2_addr_t     s_rx_addr;
  len_t         s_len;
  filter_mode_e s_mode;
  au_op_e       s_au_op;
  logic         s_au_signed;
  shift_t       s_au_shift;
  data_t        s_au_const;
  logic         s_start;
  logic         s_start_b;
  logic         s_use_const;
  logic         s_done_a;
  logic         s_done_b;
  logic         s_done_out;

  filter_l2_rd_if  s_rd_a ();
  filter_l2_rd_if  s_rd_b ();
  filter_stream_if s_port_a ();
  filter_stream_if s_port_b ();
  filter_stream_if s_opb ();
  filter_stream_if s_au_out ();

  //////////////////////////////////////////////////
  // Operand B select
  //////////////////////////////////////////////////

  assign s_use_const    = (s_mode == MODE_A_CONST);
  assign s_start_b      = s_start & ~s_use_const;         // B idle in const mode
  assign s_opb.data     = s_use_const ? s_au_const : s_port_b.data;
  assign s_opb.valid    = s_use_const | s_port_b.valid;   // Constant always valid
  assign s_opb.last     = ~s_use_const & s_port_b.last;
  assign s_port_b.ready = ~s_use_const & s_opb.ready;

  filter_cfg_regs u_cfg_regs (
    .clk_i(clk_i), .resetn_i(resetn_i),
    .cfg_addr_i(cfg_addr_i), .cfg_data_i(cfg_data_i), .cfg_valid_i(cfg_valid_i),
    .cfg_rwn_i(cfg_rwn_i), .cfg_data_o(cfg_data_o), .cfg_ready_o(cfg_ready_o),
    .txa_addr_o(s_txa_addr), .txb_addr_o(s_txb_addr), .rx_addr_o(s_rx_addr),
    .len_o(s_len), .mode_o(s_mode), .au_op_o(s_au_op), .au_signed_o(s_au_signed),
    .au_shift_o(s_au_shift), .au_const_o(s_au_const), .start_o(s_start),
    .done_a_i(s_done_a), .done_b_i(s_done_b), .done_out_i(s_done_out),
    .eot_event_o(eot_event_o)
  );

  filter_fetch_ch u_fetch_a (
    .clk_i(clk_i), .resetn_i(resetn_i), .start_i(s_start),
    .base_addr_i(s_txa_addr), .len_i(s_len),
    .rd(s_rd_a.master), .out(s_port_a.src), .done_o(s_done_a)
  );

  filter_fetch_ch u_fetch_b (
    .clk_i(clk_i), .resetn_i(resetn_i), .start_i(s_start_b),
    .base_addr_i(s_txb_addr), .len_i(s_len),
    .rd(s_rd_b.master), .out(s_port_b.src), .done_o(s_done_b)
  );

  filter_l2_arbiter u_l2_arbiter (
    .clk_i(clk_i), .resetn_i(resetn_i),
    .ch_a(s_rd_a.slave), .ch_b(s_rd_b.slave),
    .l2_rd_req_o(l2_rd_req_o), .l2_rd_addr_o(l2_rd_addr_o), .l2_rd_gnt_i(l2_rd_gnt_i),
    .l2_rd_rvalid_i(l2_rd_rvalid_i), .l2_rd_rdata_i(l2_rd_rdata_i)
  );

  filter_au u_au (
    .clk_i(clk_i), .resetn_i(resetn_i),
    .op_i(s_au_op), .signed_i(s_au_signed), .shift_i(s_au_shift),
    .opa(s_port_a.dst), .opb(s_opb.dst), .res(s_au_out.src)
  );

  filter_store_ch u_store (
    .clk_i(clk_i), .resetn_i(resetn_i), .start_i(s_start),
    .base_addr_i(s_rx_addr), .len_i(s_len), .in(s_au_out.dst),
    .rx_valid_o(rx_valid_o), .rx_addr_o(rx_addr_o), .rx_data_o(rx_data_o),
    .rx_ready_i(rx_ready_i), .done_o(s_done_out)
  );

endmodule

//--- tb/udma_filter_assertions.sv
module udma_filter_assertions
(
  input logic                 clk_i,
  input logic                 resetn_i,
  input logic                 l2_rd_req_o,
  input filter_pkg::l2_addr_t l2_rd_addr_o,
  input logic                 l2_rd_gnt_i,
  input logic                 rx_valid_o,
  input filter_pkg::l2_addr_t rx_addr_o,
  input filter_pkg::data_t    rx_data_o,
  input logic                 rx_ready_i,
  input logic                 eot_event_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Request and address stay put until granted
  a_rd_hold: assert property (@(posedge clk_i) disable iff (!resetn_i)
    (l2_rd_req_o && !l2_rd_gnt_i) |=> (l2_rd_req_o && $stable(l2_rd_addr_o)))
    else $error("L2 read request dropped or address changed before grant");

  // Write word held until the memory takes it
  a_rx_hold: assert property (@(posedge clk_i) disable iff (!resetn_i)
    (rx_valid_o && !rx_ready_i) |=>
      (rx_valid_o && $stable(rx_addr_o) && $stable(rx_data_o)))
    else $error("L2 write valid, address or data changed before rx_ready_i");

  a_eot_single: assert property (@(posedge clk_i) disable iff (!resetn_i)
    eot_event_o |=> !eot_event_o)
    else $error("eot_event_o high for two cycles in a row");

endmodule

bind udma_filter udma_filter_assertions u_assertions
(
  .clk_i(clk_i), .resetn_i(resetn_i),
  .l2_rd_req_o(l2_rd_req_o), .l2_rd_addr_o(l2_rd_addr_o), .l2_rd_gnt_i(l2_rd_gnt_i),
  .rx_valid_o(rx_valid_o), .rx_addr_o(rx_addr_o), .rx_data_o(rx_data_o),
  .rx_ready_i(rx_ready_i), .eot_event_o(eot_event_o)
);

//--- tb/udma_filter_tb.sv
`include "filter_macros.svh"

module udma_filter_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import filter_pkg::*;

  localparam int CFG_TIMEOUT = 20;
  localparam int RUN_TIMEOUT = 4000;
  localparam int MEM_IDLE    = 0;
  localparam int MEM_DELAY   = 1;
  localparam int MEM_GNT     = 2;
  localparam int MEM_DATA    = 3;
  localparam int MEM_DONE    = 4;

  logic      clk_i;
  logic      resetn_i;
  cfg_addr_t cfg_addr_i;
  data_t     cfg_data_i;
  logic      cfg_valid_i;
  logic      cfg_rwn_i;
  data_t     cfg_data_o;
  logic      cfg_ready_o;
  logic      l2_rd_req_o;
  l2_addr_t  l2_rd_addr_o;
  logic      l2_rd_gnt_i;
  logic      l2_rd_rvalid_i;
  data_t     l2_rd_rdata_i;
  logic      rx_valid_o;
  l2_addr_t  rx_addr_o;
  data_t     rx_data_o;
  logic      rx_ready_i;
  logic      eot_event_o;

  // Expected setup of the current run
  l2_addr_t     exp_txa;
  l2_addr_t     exp_txb;
  l2_addr_t     exp_rx;
  int           exp_len;
  filter_mode_e exp_mode;
  au_op_e       exp_op;
  logic         exp_sgn;
  shift_t       exp_shift;
  data_t        exp_const;

  int        value_errors = 0;
  int        proto_errors = 0;
  int        wr_count;
  int        eot_count = 0;
  int        a_reads;
  int        b_reads;
  l2_addr_t  next_a;
  l2_addr_t  next_b;
  logic [15:0] lfsr_q = 16'd4939;
  int        mem_phase;
  int        mem_cnt;
  int        rnd;
  l2_addr_t  mem_addr;
  l2_addr_t  cmp_addr;
  data_t     cmp_b;
  data_t     cmp_data;
  data_t     rd_val;

  udma_filter udma_filter_inst (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers and reference model
  //////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      v = (v << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // Memory contents hashed from the full address
  function automatic data_t mem_word(input l2_addr_t addr);
    mem_word = ({addr, 2'b01, addr} * 32'h9E37_79B1) ^ 32'hA5C3_0000;
  endfunction

  function automatic data_t au_ref(input data_t a, input data_t b, input au_op_e op,
                                   input logic sgn, input shift_t shift);
    data_t              raw;
    logic signed [31:0] sraw;
    case (op)
      AU_ADD:  raw = a + b;
      AU_SUB:  raw = a - b;
      AU_MUL:  raw = a * b;
      default: raw = a & b;
    endcase
    sraw = raw;
    au_ref = sgn ? data_t'(sraw >>> shift) : (raw >> shift);
  endfunction

  task automatic report_counts();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, proto_errors);
  endtask

  task automatic expect_low(input string name, input logic value);
    if (value !== 1'b0)
    begin
      value_errors++;
      $display("FAIL t=%0t %s got %b expected 0", $time, name, value);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    proto_errors++;
    $display("t=%0t timeout while waiting for %s", $time, what);
    report_counts();
    $display("test failed");
    $finish;
  endtask

  task automatic cfg_access(input cfg_addr_t addr, input data_t data, input logic rwn,
                            output data_t rdata);
    int cycles;
    cycles = 0;
    cfg_valid_i <= 1'b1;
    cfg_rwn_i   <= rwn;
    cfg_addr_i  <= addr;
    cfg_data_i  <= data;
    @(posedge clk_i);
    while (!cfg_ready_o)
    begin
      cycles++;
      if (cycles > CFG_TIMEOUT)
        stop_on_timeout("cfg_ready_o");
      @(posedge clk_i);
    end
    rdata = cfg_data_o;
    cfg_valid_i <= 1'b0;
  endtask

  task automatic write_and_check(input cfg_addr_t addr, input data_t data);
    data_t got;
    cfg_access(addr, data, 1'b0, got);
    cfg_access(addr, '0, 1'b1, got);
    if (got !== data)
    begin
      value_errors++;
      $display("FAIL t=%0t cfg_data_o[reg %0d] got %h expected %h", $time, addr, got, data);
    end
  endtask

  // Each channel must read its words once, in address order
  task automatic check_read_addr(input l2_addr_t addr);
    if (a_reads < exp_len && addr == next_a)
    begin
      next_a = next_a + l2_addr_t'(4);
      a_reads++;
    end
    else if (exp_mode == MODE_AB && b_reads < exp_len && addr == next_b)
    begin
      next_b = next_b + l2_addr_t'(4);
      b_reads++;
    end
    else
    begin
      proto_errors++;
      $display("t=%0t read of address %h is not the next word of an active channel",
               $time, addr);
    end
  endtask

  //////////////////////////////////////////////////
  // L2 memory model and write-side stalls
  //////////////////////////////////////////////////

  always @(posedge clk_i)
  begin
    if (!resetn_i)
    begin
      mem_phase = MEM_IDLE;
      l2_rd_gnt_i    <= 1'b0;
      l2_rd_rvalid_i <= 1'b0;
      rx_ready_i     <= 1'b0;
    end
    else
    begin
      draw_bits(2, rnd);
      rx_ready_i <= (rnd != 0);                   // Stall about one cycle in four
      case (mem_phase)
        MEM_IDLE:
        begin
          if (l2_rd_req_o)
          begin
            draw_bits(2, mem_cnt);
            mem_phase = MEM_DELAY;
          end
        end
        MEM_DELAY:
        begin
          if (mem_cnt == 0)
          begin
            l2_rd_gnt_i <= 1'b1;
            mem_phase = MEM_GNT;
          end
          else
            mem_cnt--;
        end
        MEM_GNT:
        begin
          l2_rd_gnt_i <= 1'b0;
          if (l2_rd_req_o)
          begin
            mem_addr = l2_rd_addr_o;
            check_read_addr(mem_addr);
            draw_bits(2, mem_cnt);
            mem_phase = MEM_DATA;
          end
          else
          begin
            proto_errors++;
            $display("t=%0t read request dropped while the grant was high", $time);
            mem_phase = MEM_IDLE;
          end
        end
        MEM_DATA:
        begin
          if (mem_cnt == 0)
          begin
            l2_rd_rvalid_i <= 1'b1;
            l2_rd_rdata_i  <= mem_word(mem_addr);
            mem_phase = MEM_DONE;
          end
          else
            mem_cnt--;
        end
        default:
        begin
          l2_rd_rvalid_i <= 1'b0;
          mem_phase = MEM_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Write checker
  //////////////////////////////////////////////////

  always @(posedge clk_i)
  begin
    if (resetn_i && rx_valid_o && rx_ready_i)
    begin
      if (wr_count >= exp_len)
      begin
        proto_errors++;
        $display("t=%0t more words stored than the transfer length", $time);
      end
      else
      begin
        cmp_addr = exp_rx + l2_addr_t'(4 * wr_count);
        if (exp_mode == MODE_AB)
          cmp_b = mem_word(exp_txb + l2_addr_t'(4 * wr_count));
        else
          cmp_b = exp_const;
        cmp_data = au_ref(mem_word(exp_txa + l2_addr_t'(4 * wr_count)), cmp_b,
                          exp_op, exp_sgn, exp_shift);
        if (rx_addr_o != cmp_addr)
        begin
          value_errors++;
          $display("FAIL t=%0t rx_addr_o got %h expected %h", $time, rx_addr_o, cmp_addr);
        end
        if (rx_data_o != cmp_data)
        begin
          value_errors++;
          $display("FAIL t=%0t rx_data_o got %h expected %h", $time, rx_data_o, cmp_data);
        end
      end
      wr_count++;
    end
    if (resetn_i && eot_event_o)
    begin
      eot_count++;
      if (wr_count != exp_len)
      begin
        proto_errors++;
        $display("t=%0t end-of-transfer event before all words were stored", $time);
      end
    end
  end

  task automatic run_transfer(input l2_addr_t txa, input l2_addr_t txb, input l2_addr_t rx,
                              input int len, input filter_mode_e mode, input au_op_e op,
                              input logic sgn, input shift_t shift, input data_t cval);
    int cycles;
    int eot_before;
    exp_txa   = txa;
    exp_txb   = txb;
    exp_rx    = rx;
    exp_len   = len;
    exp_mode  = mode;
    exp_op    = op;
    exp_sgn   = sgn;
    exp_shift = shift;
    exp_const = cval;
    wr_count  = 0;
    a_reads   = 0;
    b_reads   = 0;
    next_a    = txa;
    next_b    = txb;
    cfg_access(`FILTER_REG_TXA_ADDR, data_t'(txa), 1'b0, rd_val);
    cfg_access(`FILTER_REG_TXB_ADDR, data_t'(txb), 1'b0, rd_val);
    cfg_access(`FILTER_REG_RX_ADDR, data_t'(rx), 1'b0, rd_val);
    cfg_access(`FILTER_REG_LEN, data_t'(len), 1'b0, rd_val);
    cfg_access(`FILTER_REG_MODE, data_t'(mode), 1'b0, rd_val);
    cfg_access(`FILTER_REG_AU_CFG, {19'd0, shift, 5'd0, sgn, op}, 1'b0, rd_val);
    cfg_access(`FILTER_REG_AU_CONST, cval, 1'b0, rd_val);
    eot_before = eot_count;
    cfg_access(`FILTER_REG_CTRL, 32'd1, 1'b0, rd_val);    // Go
    cycles = 0;
    while (eot_count == eot_before)
    begin
      cycles++;
      if (cycles > RUN_TIMEOUT)
        stop_on_timeout("eot_event_o");
      @(posedge clk_i);
    end
    repeat (8) @(posedge clk_i);                          // Quiet window for stray pulses
    if (eot_count - eot_before != 1)
    begin
      proto_errors++;
      $display("eot_event_o pulsed %0d times in one run", eot_count - eot_before);
    end
    if (wr_count != len || a_reads != len)
    begin
      proto_errors++;
      $display("stored %0d words and read %0d A words, expected %0d", wr_count, a_reads, len);
    end
    if (b_reads != ((mode == MODE_AB) ? len : 0))
    begin
      proto_errors++;
      $display("channel B read %0d words in mode %s", b_reads, mode.name());
    end
    cfg_access(`FILTER_REG_CTRL, '0, 1'b1, rd_val);
    if (rd_val[1:0] != 2'b10)
    begin
      value_errors++;
      $display("FAIL t=%0t cfg_data_o[CTRL] got %h expected %h", $time, rd_val[1:0], 2'b10);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    resetn_i       = 1'b0;
    cfg_addr_i     = '0;
    cfg_data_i     = '0;
    cfg_valid_i    = 1'b0;
    cfg_rwn_i      = 1'b1;
    l2_rd_gnt_i    = 1'b0;
    l2_rd_rvalid_i = 1'b0;
    l2_rd_rdata_i  = '0;
    rx_ready_i     = 1'b0;
    exp_len        = 0;
    wr_count       = 0;
    repeat (2) @(posedge clk_i);
    resetn_i <= 1'b1;
    @(posedge clk_i);

    // Outputs idle after reset
    expect_low("cfg_ready_o", cfg_ready_o);
    expect_low("l2_rd_req_o", l2_rd_req_o);
    expect_low("rx_valid_o", rx_valid_o);
    expect_low("eot_event_o", eot_event_o);

    cfg_access(`FILTER_REG_CTRL, '0, 1'b1, rd_val);
    if (rd_val[0] !== 1'b0)
    begin
      value_errors++;
      $display("FAIL t=%0t cfg_data_o[CTRL busy] got %b expected 0", $time, rd_val[0]);
    end
    write_and_check(`FILTER_REG_TXA_ADDR, 32'h0000_1A2C);
    write_and_check(`FILTER_REG_TXB_ADDR, 32'h0000_2B40);
    write_and_check(`FILTER_REG_LEN, 32'h0000_BEEF);
    write_and_check(`FILTER_REG_RX_ADDR, 32'h0000_7FFC);
    write_and_check(`FILTER_REG_MODE, 32'h0000_0001);
    write_and_check(`FILTER_REG_AU_CFG, 32'h0000_1F07);
    write_and_check(`FILTER_REG_AU_CONST, 32'hDEAD_BEEF);

    run_transfer(15'h0100, 15'h0400, 15'h1000, 16, MODE_AB, AU_ADD, 1'b0, 5'd0, '0);
    run_transfer(15'h0800, 15'h0C00, 15'h1400, 12, MODE_A_CONST, AU_SUB, 1'b1, 5'd3,
                 32'h1234_5678);
    run_transfer(15'h2000, 15'h2400, 15'h3000, 10, MODE_AB, AU_MUL, 1'b0, 5'd5, '0);
    run_transfer(15'h2200, 15'h2600, 15'h3400, 9, MODE_A_CONST, AU_AND, 1'b0, 5'd4,
                 32'h8F0F_F00F);

    report_counts();
    if (value_errors == 0 && proto_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- udma_filter.f
+incdir+include
rtl/filter_pkg.sv
rtl/filter_ifs.sv
rtl/filter_cfg_regs.sv
rtl/filter_fetch_ch.sv
rtl/filter_l2_arbiter.sv
rtl/filter_au.sv
rtl/filter_store_ch.sv
rtl/udma_filter.sv
tb/udma_filter_assertions.sv
tb/udma_filter_tb.sv
